// ==== cpu_core.f ====
hw/cpu_pkg.sv
hw/boot_loader.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_core.sv
test/cpu_mem_model.sv
test/cpu_core_tb.sv

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb
  import cpu_pkg::*;
();

  localparam int IM_ADDR_W  = 10;
  localparam int DM_ADDR_W  = 15;
  localparam int ROM_ADDR_W = 8;

  logic                  clk;
  logic                  rst;
  logic                  sys_en;
  word_t                 instr;
  word_t                 dm_rdata;
  rom_word_t             rom_data;
  logic                  im_en;
  logic                  im_rd;
  logic                  im_wr;
  logic [IM_ADDR_W-1:0]  im_addr;
  word_t                 im_wdata;
  logic                  dm_en;
  logic                  dm_rd;
  logic                  dm_wr;
  logic [DM_ADDR_W-1:0]  dm_addr;
  word_t                 dm_wdata;
  logic                  rom_en;
  logic [ROM_ADDR_W-1:0] rom_addr;
  logic                  boot_done;

  int    error_count;
  int    check_count;
  int    cycle;
  int    boot_cycle;
  word_t prog[$];
  word_t exp_addr[$];
  word_t exp_data[$];
  word_t log_addr[$];
  word_t log_data[$];
  int    log_cycle[$];

  cpu_core #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W), .ROM_ADDR_W(ROM_ADDR_W)) dut_i (
    .i_clk(clk), .i_rst(rst), .i_system_enable(sys_en), .i_instr(instr),
    .i_dm_rdata(dm_rdata), .i_rom_data(rom_data),
    .o_im_enable(im_en), .o_im_read(im_rd), .o_im_write(im_wr), .o_im_addr(im_addr),
    .o_im_wdata(im_wdata), .o_dm_enable(dm_en), .o_dm_read(dm_rd), .o_dm_write(dm_wr),
    .o_dm_addr(dm_addr), .o_dm_wdata(dm_wdata), .o_rom_enable(rom_en),
    .o_rom_addr(rom_addr), .o_boot_done(boot_done)
  );

  cpu_mem_model #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W), .ROM_ADDR_W(ROM_ADDR_W)) mem_i (
    .i_clk(clk), .i_rom_enable(rom_en), .i_rom_addr(rom_addr), .o_rom_data(rom_data),
    .i_im_enable(im_en), .i_im_read(im_rd), .i_im_write(im_wr), .i_im_addr(im_addr),
    .i_im_wdata(im_wdata), .o_im_rdata(instr), .i_dm_enable(dm_en), .i_dm_read(dm_rd),
    .i_dm_write(dm_wr), .i_dm_addr(dm_addr), .i_dm_wdata(dm_wdata), .o_dm_rdata(dm_rdata)
  );

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // dm write log sampled at the edge where the write lands
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!rst && dm_en === 1'b1 && dm_wr === 1'b1) begin
      log_addr.push_back(word_t'(dm_addr));
      log_data.push_back(dm_wdata);
      log_cycle.push_back(cycle);
    end
    if (dm_wr === 1'b1 && boot_done !== 1'b1) begin
      report_error("DM write seen before boot done");
    end
    // first cycle with boot done fetches im address 0
    if (!rst && boot_done === 1'b1 && boot_cycle < 0) begin
      boot_cycle = cycle;
    end
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // instruction builders taking register and immediate fields as ints
  function automatic word_t make_alu(input subop_t sub, input int rt, input int ra, input int rb);
    return {1'b0, OP_ALU, reg_addr_t'(rt), reg_addr_t'(ra), reg_addr_t'(rb), 5'b0, sub};
  endfunction

  function automatic word_t make_imm(input opcode_t op, input int rt, input int ra, input int imm);
    return {1'b0, op, reg_addr_t'(rt), reg_addr_t'(ra), 15'(imm)};
  endfunction

  function automatic word_t make_movi(input int rt, input int imm);
    return {1'b0, OP_MOVI, reg_addr_t'(rt), 20'(imm)};
  endfunction

  // odd multiplier gives every address its own word
  function automatic word_t dm_fill(input int addr);
    return 32'h3c5a_0000 ^ (word_t'(addr) * 32'h0009_e377);
  endfunction

  // two nops after each instruction since the core has no forwarding
  task automatic emit(input word_t w);
    prog.push_back(w);
    prog.push_back('0);
    prog.push_back('0);
  endtask

  // r31 must hold 12 before this
  task automatic load_const(input int rd, input word_t value);
    emit(make_movi(rd, int'(value[31:12])));
    emit(make_alu(SUB_SLL, rd, rd, 31));
    emit(make_imm(OP_ORI, rd, rd, int'(value[11:0])));
  endtask

  task automatic expect_write(input int addr, input word_t data);
    exp_addr.push_back(word_t'(addr) & ((32'd1 << DM_ADDR_W) - 32'd1));
    exp_data.push_back(data);
  endtask

  task automatic start_test(input string name);
    $display("test: %s", name);
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  // reset, load rom and im, then boot with a timeout
  task automatic boot_program();
    int n;
    int waited;
    n = prog.size();
    @(posedge clk);
    rst    <= 1'b1;
    sys_en <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 2**IM_ADDR_W; i++) begin
      mem_i.im[i] = '0;
    end
    for (int i = 0; i < n; i++) begin
      mem_i.rom[i] = {(i == n - 1), 3'b000, prog[i]};
    end
    log_addr.delete();
    log_data.delete();
    log_cycle.delete();
    boot_cycle = -1;
    repeat (9) @(posedge clk);
    // memory strobes and boot done all low in reset
    check_value("reset {rom_en,im_en,im_rd,im_wr,dm_en,dm_rd,dm_wr,boot_done}",
                word_t'({rom_en, im_en, im_rd, im_wr, dm_en, dm_rd, dm_wr, boot_done}),
                32'd0);
    rst    <= 1'b0;
    sys_en <= 1'b1;
    waited = 0;
    while (boot_done !== 1'b1 && waited < n + 20) begin
      @(posedge clk);
      waited++;
    end
    if (boot_done !== 1'b1) begin
      report_error("timeout waiting for boot done");
    end
  endtask

  // wait for the expected stores, then compare in program order
  task automatic collect_writes();
    int waited;
    waited = 0;
    while (log_addr.size() < exp_addr.size() && waited < 300) begin
      @(posedge clk);
      waited++;
    end
    if (log_addr.size() < exp_addr.size()) begin
      report_error("timeout waiting for DM writes");
    end
    // program tail is nops so nothing more should show up
    repeat (10) @(posedge clk);
    check_value("dm write count", word_t'(log_addr.size()), word_t'(exp_addr.size()));
    for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
      check_value($sformatf("dm_addr[%0d]", i), log_addr[i], exp_addr[i]);
      check_value($sformatf("dm_wdata[%0d]", i), log_data[i], exp_data[i]);
    end
  endtask

  task automatic test_boot();
    start_test("boot");
    for (int i = 0; i < 12; i++) begin
      prog.push_back(make_movi(i + 1, int'($urandom)));
    end
    boot_program();
    for (int i = 0; i < 12; i++) begin
      check_value($sformatf("im[%0d]", i), mem_i.im[i], prog[i]);
    end
    check_value("im[12]", mem_i.im[12], '0);
    // fetch owns the im port now
    repeat (5) begin
      @(posedge clk);
      check_value("im_write after boot", word_t'(im_wr), 32'd0);
      check_value("im_read after boot", word_t'(im_rd), 32'd1);
      check_value("rom_enable after boot", word_t'(rom_en), 32'd0);
    end
  endtask

  task automatic test_imm();
    logic [19:0] mv;
    logic [14:0] ai;
    logic [14:0] oi;
    word_t       r1;
    start_test("immediate forms");
    mv = 20'h8_1234;
    ai = 15'h7ff0;
    oi = 15'h5a5a;
    emit(make_movi(1, int'(mv)));
    emit(make_imm(OP_ADDI, 2, 1, int'(ai)));
    emit(make_imm(OP_ORI, 3, 1, int'(oi)));
    emit(make_imm(OP_SWI, 1, 0, 100));
    emit(make_imm(OP_SWI, 2, 0, 101));
    emit(make_imm(OP_SWI, 3, 0, 102));
    // sign extended 20, sign extended 15, zero extended 15
    r1 = word_t'($signed(mv));
    expect_write(100, r1);
    expect_write(101, r1 + word_t'($signed(ai)));
    expect_write(102, r1 | word_t'(oi));
    boot_program();
    collect_writes();
  endtask

  task automatic test_alu();
    word_t  a;
    word_t  b;
    subop_t subs [7];
    word_t  want [7];
    start_test("register alu");
    a = $urandom;
    b = $urandom;
    subs = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR, SUB_SLL, SUB_SRL};
    want = '{a + b, a - b, a & b, a | b, a ^ b, a << b[4:0], a >> b[4:0]};
    emit(make_movi(31, 12));
    load_const(1, a);
    load_const(2, b);
    for (int i = 0; i < 7; i++) begin
      emit(make_alu(subs[i], i + 5, 1, 2));
    end
    for (int i = 0; i < 7; i++) begin
      emit(make_imm(OP_SWI, i + 5, 0, 200 + i));
      expect_write(200 + i, want[i]);
    end
    boot_program();
    collect_writes();
  endtask

  task automatic test_load_store();
    start_test("load and store");
    // base 290, load from 300, store to 283
    emit(make_movi(2, 290));
    emit(make_imm(OP_LWI, 1, 2, 10));
    emit(make_imm(OP_ADDI, 1, 1, 1));
    emit(make_imm(OP_SWI, 1, 2, -7));
    expect_write(290 - 7, dm_fill(300) + 32'd1);
    boot_program();
    collect_writes();
  endtask

  task automatic test_store_timing();
    start_test("store timing");
    emit(make_movi(3, 77));
    prog.push_back('0);
    prog.push_back('0);
    // store sits at im address 5
    prog.push_back(make_imm(OP_SWI, 3, 0, 400));
    prog.push_back('0);
    prog.push_back('0);
    expect_write(400, 32'd77);
    boot_program();
    collect_writes();
    if (log_cycle.size() > 0) begin
      check_value("store latency", word_t'(log_cycle[0] - boot_cycle), word_t'(5 + 3));
    end
  endtask

  task automatic test_reg_zero();
    start_test("register 0");
    emit(make_movi(0, 123));
    emit(make_imm(OP_ADDI, 0, 0, 55));
    emit(make_imm(OP_SWI, 0, 0, 500));
    expect_write(500, '0);
    boot_program();
    collect_writes();
  endtask

  initial begin
    int seed_draw;
    rst         <= 1'b1;
    sys_en      <= 1'b0;
    error_count = 0;
    check_count = 0;
    cycle       = 0;
    boot_cycle  = -1;
    seed_draw   = $urandom(22);
    for (int a = 0; a < 2**DM_ADDR_W; a++) begin
      mem_i.dm[a] = dm_fill(a);
    end
    test_boot();
    test_imm();
    test_alu();
    test_load_store();
    test_store_timing();
    test_reg_zero();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/cpu_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_model
  import cpu_pkg::*;
#(
  parameter int IM_ADDR_W  = 10,
  parameter int DM_ADDR_W  = 15,
  parameter int ROM_ADDR_W = 8
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rom_enable,
  input  wire logic [ROM_ADDR_W-1:0] i_rom_addr,
  output rom_word_t                  o_rom_data,
  input  wire logic                  i_im_enable,
  input  wire logic                  i_im_read,
  input  wire logic                  i_im_write,
  input  wire logic [IM_ADDR_W-1:0]  i_im_addr,
  input  wire word_t                 i_im_wdata,
  output word_t                      o_im_rdata,
  input  wire logic                  i_dm_enable,
  input  wire logic                  i_dm_read,
  input  wire logic                  i_dm_write,
  input  wire logic [DM_ADDR_W-1:0]  i_dm_addr,
  input  wire word_t                 i_dm_wdata,
  output word_t                      o_dm_rdata
);

  // contents loaded and inspected by the testbench
  rom_word_t rom [2**ROM_ADDR_W];
  word_t     im  [2**IM_ADDR_W];
  word_t     dm  [2**DM_ADDR_W];

  // reads answer in the same cycle
  assign o_rom_data = i_rom_enable ? rom[i_rom_addr] : '0;
  assign o_im_rdata = (i_im_enable && i_im_read) ? im[i_im_addr] : '0;
  assign o_dm_rdata = (i_dm_enable && i_dm_read) ? dm[i_dm_addr] : '0;

  // writes land at the rising edge
  always @(posedge i_clk) begin
    if (i_im_enable && i_im_write) begin
      im[i_im_addr] <= i_im_wdata;
    end
  end

  always @(posedge i_clk) begin
    if (i_dm_enable && i_dm_write) begin
      dm[i_dm_addr] <= i_dm_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core
  import cpu_pkg::*;
#(
  parameter int IM_ADDR_W  = 10,
  parameter int DM_ADDR_W  = 15,
  parameter int ROM_ADDR_W = 8
) (
  input  wire logic             i_clk,
  input  wire logic             i_rst,
  input  wire logic             i_system_enable,
  input  wire word_t            i_instr,
  input  wire word_t            i_dm_rdata,
  input  wire rom_word_t        i_rom_data,
  output logic                  o_im_enable,
  output logic                  o_im_read,
  output logic                  o_im_write,
  output logic [IM_ADDR_W-1:0]  o_im_addr,
  output word_t                 o_im_wdata,
  output logic                  o_dm_enable,
  output logic                  o_dm_read,
  output logic                  o_dm_write,
  output logic [DM_ADDR_W-1:0]  o_dm_addr,
  output word_t                 o_dm_wdata,
  output logic                  o_rom_enable,
  output logic [ROM_ADDR_W-1:0] o_rom_addr,
  output logic                  o_boot_done
);

  // boot side of the im port
  logic                 boot_im_enable;
  logic                 boot_im_write;
  logic [IM_ADDR_W-1:0] boot_im_addr;
  word_t                boot_im_wdata;
  logic                 boot_done;

  word_t     pc;
  word_t     instr_id;
  reg_addr_t ra_addr, rb_addr, rt_addr;
  word_t     ra_data, rb_data, rt_data;

  // id/ex
  alu_op_e   ex_alu_op;
  logic      ex_alu_src_imm, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg;
  word_t     ex_imm, ex_src1, ex_src2, ex_store_data;
  reg_addr_t ex_dest;

  // ex/mem
  word_t     mem_alu_result;
  logic      mem_reg_write, mem_to_reg;
  reg_addr_t mem_dest;

  // write back
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  boot_loader #(.IM_ADDR_W(IM_ADDR_W), .ROM_ADDR_W(ROM_ADDR_W)) boot_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_system_enable(i_system_enable),
    .i_rom_data(i_rom_data), .o_rom_enable(o_rom_enable), .o_rom_addr(o_rom_addr),
    .o_im_enable(boot_im_enable), .o_im_write(boot_im_write),
    .o_im_addr(boot_im_addr), .o_im_wdata(boot_im_wdata), .o_boot_done(boot_done)
  );

  // im belongs to the boot loader until done, then to fetch
  assign o_im_enable = boot_done ? 1'b1 : boot_im_enable;
  assign o_im_read   = boot_done;
  assign o_im_write  = boot_done ? 1'b0 : boot_im_write;
  assign o_im_addr   = boot_done ? pc[IM_ADDR_W-1:0] : boot_im_addr;
  assign o_im_wdata  = boot_im_wdata;
  assign o_boot_done = boot_done;

  // whole pipeline steps on boot_done, no stalls
  fetch_stage #(.IM_ADDR_W(IM_ADDR_W)) fetch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_advance(boot_done), .i_instr(i_instr),
    .o_pc(pc), .o_instr_id(instr_id)
  );

  decode_stage decode_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_advance(boot_done), .i_instr_id(instr_id),
    .i_ra_data(ra_data), .i_rb_data(rb_data), .i_rt_data(rt_data),
    .o_ra_addr(ra_addr), .o_rb_addr(rb_addr), .o_rt_addr(rt_addr),
    .o_alu_op(ex_alu_op), .o_alu_src_imm(ex_alu_src_imm), .o_mem_read(ex_mem_read),
    .o_mem_write(ex_mem_write), .o_reg_write(ex_reg_write), .o_mem_to_reg(ex_mem_to_reg),
    .o_imm(ex_imm), .o_src1(ex_src1), .o_src2(ex_src2), .o_store_data(ex_store_data),
    .o_dest(ex_dest)
  );

  reg_file rf_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_ra_addr(ra_addr), .i_rb_addr(rb_addr),
    .i_rt_addr(rt_addr), .i_wr_en(wb_en), .i_wr_addr(wb_addr), .i_wr_data(wb_data),
    .o_ra_data(ra_data), .o_rb_data(rb_data), .o_rt_data(rt_data)
  );

  execute_stage #(.DM_ADDR_W(DM_ADDR_W)) execute_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_advance(boot_done), .i_alu_op(ex_alu_op),
    .i_alu_src_imm(ex_alu_src_imm), .i_mem_read(ex_mem_read), .i_mem_write(ex_mem_write),
    .i_reg_write(ex_reg_write), .i_mem_to_reg(ex_mem_to_reg), .i_imm(ex_imm),
    .i_src1(ex_src1), .i_src2(ex_src2), .i_store_data(ex_store_data), .i_dest(ex_dest),
    .o_alu_result(mem_alu_result), .o_dm_enable(o_dm_enable), .o_dm_addr(o_dm_addr),
    .o_dm_wdata(o_dm_wdata), .o_mem_read(o_dm_read), .o_mem_write(o_dm_write),
    .o_reg_write(mem_reg_write), .o_mem_to_reg(mem_to_reg), .o_dest(mem_dest)
  );

  mem_wb_stage mem_wb_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_advance(boot_done), .i_alu_result(mem_alu_result),
    .i_dm_rdata(i_dm_rdata), .i_mem_to_reg(mem_to_reg), .i_reg_write(mem_reg_write),
    .i_dest(mem_dest), .o_wr_en(wb_en), .o_wr_addr(wb_addr), .o_wr_data(wb_data)
  );

endmodule

`default_nettype wire

// ==== hw/mem_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
  import cpu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_rst,
  input  wire logic      i_advance,
  input  wire word_t     i_alu_result,
  input  wire word_t     i_dm_rdata,
  input  wire logic      i_mem_to_reg,
  input  wire logic      i_reg_write,
  input  wire reg_addr_t i_dest,
  output logic           o_wr_en,
  output reg_addr_t      o_wr_addr,
  output word_t          o_wr_data
);

  word_t alu_q;
  word_t load_q;
  logic  mem_to_reg_q;

  // mem/wb register, dm read data arrives same cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      alu_q        <= '0;
      load_q       <= '0;
      mem_to_reg_q <= 1'b0;
      o_wr_en      <= 1'b0;
      o_wr_addr    <= '0;
    end else if (i_advance) begin
      alu_q        <= i_alu_result;
      load_q       <= i_dm_rdata;
      mem_to_reg_q <= i_mem_to_reg;
      o_wr_en      <= i_reg_write;
      o_wr_addr    <= i_dest;
    end
  end

  // loads write memory data, everything else the alu result
  assign o_wr_data = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import cpu_pkg::*;
#(
  parameter int DM_ADDR_W = 15
) (
  input  wire logic       i_clk,
  input  wire logic       i_rst,
  input  wire logic       i_advance,
  input  wire alu_op_e    i_alu_op,
  input  wire logic       i_alu_src_imm,
  input  wire logic       i_mem_read,
  input  wire logic       i_mem_write,
  input  wire logic       i_reg_write,
  input  wire logic       i_mem_to_reg,
  input  wire word_t      i_imm,
  input  wire word_t      i_src1,
  input  wire word_t      i_src2,
  input  wire word_t      i_store_data,
  input  wire reg_addr_t  i_dest,
  output word_t           o_alu_result,
  output logic            o_dm_enable,
  output logic [DM_ADDR_W-1:0] o_dm_addr,
  output word_t           o_dm_wdata,
  output logic            o_mem_read,
  output logic            o_mem_write,
  output logic            o_reg_write,
  output logic            o_mem_to_reg,
  output reg_addr_t       o_dest
);

  word_t opnd_b;
  word_t result;

  // second operand, register or immediate
  assign opnd_b = i_alu_src_imm ? i_imm : i_src2;

  always_comb begin
    case (i_alu_op)
      ALU_ADD: result = i_src1 + opnd_b;
      ALU_SUB: result = i_src1 - opnd_b;
      ALU_AND: result = i_src1 & opnd_b;
      ALU_OR:  result = i_src1 | opnd_b;
      ALU_XOR: result = i_src1 ^ opnd_b;
      // shift amount from low 5 bits only
      ALU_SLL: result = i_src1 << opnd_b[4:0];
      ALU_SRL: result = i_src1 >> opnd_b[4:0];
      default: result = '0;
    endcase
  end

  // ex/mem register, drives the dm ports directly
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_alu_result <= '0;
      o_dm_enable  <= 1'b0;
      o_dm_addr    <= '0;
      o_dm_wdata   <= '0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_reg_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
      o_dest       <= '0;
    end else if (i_advance) begin
      o_alu_result <= result;
      o_dm_enable  <= i_mem_read | i_mem_write;
      // word address, truncated alu sum
      o_dm_addr    <= result[DM_ADDR_W-1:0];
      o_dm_wdata   <= i_store_data;
      o_mem_read   <= i_mem_read;
      o_mem_write  <= i_mem_write;
      o_reg_write  <= i_reg_write;
      o_mem_to_reg <= i_mem_to_reg;
      o_dest       <= i_dest;
    end
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import cpu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_rst,
  input  wire reg_addr_t i_ra_addr,
  input  wire reg_addr_t i_rb_addr,
  input  wire reg_addr_t i_rt_addr,
  input  wire logic      i_wr_en,
  input  wire reg_addr_t i_wr_addr,
  input  wire word_t     i_wr_data,
  output word_t          o_ra_data,
  output word_t          o_rb_data,
  output word_t          o_rt_data
);

  word_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (i_wr_en && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // r0 reads zero and a same-cycle write wins over the stored value
  assign o_ra_data = (i_ra_addr == '0) ? '0 :
                     (i_wr_en && (i_wr_addr == i_ra_addr)) ? i_wr_data : regs[i_ra_addr];
  assign o_rb_data = (i_rb_addr == '0) ? '0 :
                     (i_wr_en && (i_wr_addr == i_rb_addr)) ? i_wr_data : regs[i_rb_addr];
  assign o_rt_data = (i_rt_addr == '0) ? '0 :
                     (i_wr_en && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import cpu_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst,
  input  wire logic  i_advance,
  input  wire word_t i_instr_id,
  input  wire word_t i_ra_data,
  input  wire word_t i_rb_data,
  input  wire word_t i_rt_data,
  output reg_addr_t  o_ra_addr,
  output reg_addr_t  o_rb_addr,
  output reg_addr_t  o_rt_addr,
  output alu_op_e    o_alu_op,
  output logic       o_alu_src_imm,
  output logic       o_mem_read,
  output logic       o_mem_write,
  output logic       o_reg_write,
  output logic       o_mem_to_reg,
  output word_t      o_imm,
  output word_t      o_src1,
  output word_t      o_src2,
  output word_t      o_store_data,
  output reg_addr_t  o_dest
);

  opcode_t   opcode;
  subop_t    subop;
  imm_sel_e  imm_sel;
  alu_op_e   alu_op;
  logic      alu_src_imm;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  logic      mem_to_reg;
  logic      zero_src1;
  logic      illegal;
  word_t     imm;

  assign opcode    = i_instr_id[30:25];
  assign subop     = i_instr_id[4:0];
  // register read addresses straight from the fields
  assign o_rt_addr = i_instr_id[24:20];
  assign o_ra_addr = i_instr_id[19:15];
  assign o_rb_addr = i_instr_id[14:10];

  always_comb begin
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    reg_write   = 1'b0;
    mem_to_reg  = 1'b0;
    zero_src1   = 1'b0;
    imm_sel     = IMM_NONE;
    illegal     = 1'b0;
    case (opcode)
      OP_ALU: begin
        reg_write = 1'b1;
        case (subop)
          SUB_ADD: alu_op = ALU_ADD;
          SUB_SUB: alu_op = ALU_SUB;
          SUB_AND: alu_op = ALU_AND;
          SUB_OR:  alu_op = ALU_OR;
          SUB_XOR: alu_op = ALU_XOR;
          SUB_SLL: alu_op = ALU_SLL;
          SUB_SRL: alu_op = ALU_SRL;
          default: begin
            reg_write = 1'b0;
            illegal   = 1'b1;
          end
        endcase
      end
      OP_ADDI: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm_sel     = IMM_SE15;
      end
      OP_ORI: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm_sel     = IMM_ZE15;
        alu_op      = ALU_OR;
      end
      OP_MOVI: begin
        // 0 + imm20 since the ra field overlaps the immediate
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm_sel     = IMM_SE20;
        zero_src1   = 1'b1;
      end
      OP_LWI: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm_sel     = IMM_SE15;
        mem_read    = 1'b1;
        mem_to_reg  = 1'b1;
      end
      OP_SWI: begin
        alu_src_imm = 1'b1;
        imm_sel     = IMM_SE15;
        mem_write   = 1'b1;
      end
      // all-zero word is the nop and anything else here is unknown
      default: illegal = (i_instr_id != '0);
    endcase
  end

  // immediate extension
  always_comb begin
    case (imm_sel)
      IMM_SE15: imm = {{17{i_instr_id[14]}}, i_instr_id[14:0]};
      IMM_ZE15: imm = {17'b0, i_instr_id[14:0]};
      IMM_SE20: imm = {{12{i_instr_id[19]}}, i_instr_id[19:0]};
      default:  imm = '0;
    endcase
  end

  // id/ex register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      {o_alu_src_imm, o_mem_read, o_mem_write, o_reg_write, o_mem_to_reg} <= '0;
      o_alu_op     <= ALU_ADD;
      o_imm        <= '0;
      o_src1       <= '0;
      o_src2       <= '0;
      o_store_data <= '0;
      o_dest       <= '0;
    end else if (i_advance) begin
      {o_alu_src_imm, o_mem_read, o_mem_write} <= {alu_src_imm, mem_read, mem_write};
      {o_reg_write, o_mem_to_reg}              <= {reg_write, mem_to_reg};
      o_alu_op     <= alu_op;
      o_imm        <= imm;
      o_src1       <= zero_src1 ? '0 : i_ra_data;
      o_src2       <= i_rb_data;
      o_store_data <= i_rt_data;
      o_dest       <= o_rt_addr;
    end
  end

  // flag an unknown instruction entering the pipeline
  a_no_illegal: assert property (@(posedge i_clk) disable iff (i_rst)
    i_advance |-> !illegal);

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import cpu_pkg::*;
#(
  parameter int IM_ADDR_W = 10
) (
  input  wire logic  i_clk,
  input  wire logic  i_rst,
  input  wire logic  i_advance,
  input  wire word_t i_instr,
  output word_t      o_pc,
  output word_t      o_instr_id
);

  word_t                 pc_q;
  word_t                 instr_q;
  logic [IM_ADDR_W-1:0]  pc_next_idx;

  // word addressed pc, wraps inside instruction memory
  assign pc_next_idx = pc_q[IM_ADDR_W-1:0] + 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= '0;
    end else if (i_advance) begin
      pc_q <= word_t'(pc_next_idx);
    end
  end

  // if/id register, zero word is a nop until the first advance
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      instr_q <= '0;
    end else if (i_advance) begin
      instr_q <= i_instr;
    end
  end

  assign o_pc       = pc_q;
  assign o_instr_id = instr_q;

endmodule

`default_nettype wire

// ==== hw/boot_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_loader
  import cpu_pkg::*;
#(
  parameter int IM_ADDR_W  = 10,
  parameter int ROM_ADDR_W = 8
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_system_enable,
  input  wire rom_word_t             i_rom_data,
  output logic                       o_rom_enable,
  output logic [ROM_ADDR_W-1:0]      o_rom_addr,
  output logic                       o_im_enable,
  output logic                       o_im_write,
  output logic [IM_ADDR_W-1:0]       o_im_addr,
  output word_t                      o_im_wdata,
  output logic                       o_boot_done
);

  boot_state_e             state_q;
  boot_state_e             state_d;
  logic [ROM_ADDR_W-1:0]   addr_q;
  logic                    copying;

  assign copying = (state_q == BOOT_COPY);

  // leave copy once the marked word is written
  always_comb begin
    state_d = state_q;
    case (state_q)
      BOOT_IDLE: if (i_system_enable) state_d = BOOT_COPY;
      BOOT_COPY: if (i_rom_data[35]) state_d = BOOT_DONE;
      default:   state_d = BOOT_DONE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= BOOT_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // one rom word per cycle while copying
      if (copying) addr_q <= addr_q + 1'b1;
    end
  end

  // rom word lands in im at the same index in the same cycle
  assign o_rom_enable = copying;
  assign o_rom_addr   = addr_q;
  assign o_im_enable  = copying;
  assign o_im_write   = copying;
  assign o_im_addr    = IM_ADDR_W'(addr_q);
  assign o_im_wdata   = i_rom_data[31:0];
  assign o_boot_done  = (state_q == BOOT_DONE);

  // the marker must show up before the rom address wraps
  a_rom_no_wrap: assert property (@(posedge i_clk) disable iff (i_rst)
    (copying && (&addr_q)) |-> i_rom_data[35]);

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // data, instruction and address values
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0]  reg_addr_t;
  // rom word: bit 35 last-word marker, 34..32 reserved, 31..0 instruction
  typedef logic [35:0] rom_word_t;
  // primary opcode, instruction bits 30..25
  typedef logic [5:0]  opcode_t;
  // alu sub-opcode, instruction bits 4..0
  typedef logic [4:0]  subop_t;

  // primary opcodes
  localparam opcode_t OP_ALU  = 6'b100000;
  localparam opcode_t OP_ADDI = 6'b101000;
  localparam opcode_t OP_ORI  = 6'b101100;
  localparam opcode_t OP_MOVI = 6'b100010;
  localparam opcode_t OP_LWI  = 6'b000010;
  localparam opcode_t OP_SWI  = 6'b001010;

  // sub-opcodes under OP_ALU
  localparam subop_t SUB_ADD = 5'b00000;
  localparam subop_t SUB_SUB = 5'b00001;
  localparam subop_t SUB_AND = 5'b00010;
  localparam subop_t SUB_XOR = 5'b00011;
  localparam subop_t SUB_OR  = 5'b00100;
  localparam subop_t SUB_SLL = 5'b01100;
  localparam subop_t SUB_SRL = 5'b01101;

  // which extended immediate feeds the alu
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_SE15,
    IMM_ZE15,
    IMM_SE20
  } imm_sel_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  typedef enum logic [1:0] {
    BOOT_IDLE,
    BOOT_COPY,
    BOOT_DONE
  } boot_state_e;

endpackage

`default_nettype wire
